/* Makefile */
# Verilator flow for the 8-point FFT

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tb_fft
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/fft_butterfly.sv */
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_butterfly (
  input  fft_pkg::fft_cplx_t a,
  input  fft_pkg::fft_cplx_t b,
  input  fft_pkg::fft_cplx_t twiddle,
  output fft_pkg::fft_cplx_t sum,
  output fft_pkg::fft_cplx_t diff
);

  import fft_pkg::*;

  // partial products of b * twiddle
  fft_word_t rr;
  fft_word_t ii;
  fft_word_t ri;
  fft_word_t ir;

  // the rotated bottom input
  fft_cplx_t prod;

  always_comb begin
    rr = fft_fx_mul(b.re, twiddle.re);
    ii = fft_fx_mul(b.im, twiddle.im);
    ri = fft_fx_mul(b.re, twiddle.im);
    ir = fft_fx_mul(b.im, twiddle.re);
  end

  // each partial is truncated on its own before the sum, as in the
  // reference model that generates the expected spectra
  always_comb begin
    prod.re = rr - ii;
    prod.im = ri + ir;
  end

  always_comb begin
    sum.re  = a.re + prod.re;
    sum.im  = a.im + prod.im;
    diff.re = a.re - prod.re;  // wraps on overflow, no saturation
    diff.im = a.im - prod.im;
  end

endmodule

/* hdl/fft_pkg.sv */
`include "fft_defs.svh"

package fft_pkg;

  // one signed Q16.16 word
  typedef logic signed [`FFT_BIT_WIDTH-1:0] fft_word_t;

  // complex value, real part in the upper word
  typedef struct packed {
    fft_word_t re;
    fft_word_t im;
  } fft_cplx_t;

  // a frame of real input samples, index 0 is the first sample in time
  typedef fft_word_t [`FFT_N_SAMPLES-1:0] fft_real_frame_t;

  // a complex frame between stages and at the output
  typedef fft_cplx_t [`FFT_N_SAMPLES-1:0] fft_cplx_frame_t;

  // twiddle factors W_N^k = cos(2*pi*k/N) - j*sin(2*pi*k/N)
  // values are rounded to the nearest Q16.16 step, so 1/sqrt(2) becomes 46341
  localparam fft_cplx_t fft_twiddle [`FFT_N_SAMPLES/2] = '{
    '{
      re: fft_word_t'(65536),   // k = 0, angle 0
      im: fft_word_t'(0)
    },
    '{
      re: fft_word_t'(46341),   // k = 1, angle pi/4
      im: fft_word_t'(-46341)
    },
    '{
      re: fft_word_t'(0),       // k = 2, angle pi/2
      im: fft_word_t'(-65536)
    },
    '{
      re: fft_word_t'(-46341),  // k = 3, angle 3*pi/4
      im: fft_word_t'(-46341)
    }
  };

  // fixed-point multiply
  // the full product has twice the fraction bits, so the low DECIMAL_PT bits
  // are dropped by an arithmetic shift which truncates toward minus infinity
  function automatic fft_word_t fft_fx_mul(
    input fft_word_t x,
    input fft_word_t y
  );
    logic signed [2*`FFT_BIT_WIDTH-1:0] prod;
    logic signed [2*`FFT_BIT_WIDTH-1:0] shifted;
    prod    = x * y;  // both operands signed, so they sign extend to 64 bits
    shifted = prod >>> `FFT_DECIMAL_PT;
    return fft_word_t'(shifted);
  endfunction

endpackage

/* hdl/fft_stage.sv */
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_stage #(
  parameter int STAGE = 0
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  fft_pkg::fft_cplx_frame_t recv_msg,
  input  logic                     recv_val,
  output logic                     recv_rdy,

  output fft_pkg::fft_cplx_frame_t send_msg,
  output logic                     send_val,
  input  logic                     send_rdy
);

  import fft_pkg::*;

  // distance between the two inputs of a butterfly
  localparam int HALF = 1 << STAGE;
  // size of a butterfly group, the twiddle stride follows from it
  localparam int SPAN = 2 * HALF;

  fft_cplx_frame_t next_msg;  // combinational result of all butterflies

  // butterfly b sits in group b/HALF at position b%HALF of that group
  for (genvar b = 0; b < `FFT_N_SAMPLES / 2; b++) begin : g_bfly
    localparam int GRP = b / HALF;
    localparam int J   = b % HALF;
    localparam int TOP = GRP * SPAN + J;
    localparam int BOT = TOP + HALF;
    localparam int TW  = J * `FFT_N_SAMPLES / SPAN;

    fft_butterfly u_bfly (
      .a      (recv_msg[TOP]),
      .b      (recv_msg[BOT]),
      .twiddle(fft_twiddle[TW]),
      .sum    (next_msg[TOP]),
      .diff   (next_msg[BOT])
    );
  end

  // the output register is free when it is empty or drains this cycle
  assign recv_rdy = !send_val || send_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      send_val <= 1'b0;
    end else if (recv_rdy) begin
      send_val <= recv_val;  // a bubble clears the valid once the frame leaves
    end
  end

  // payload only moves on a real transfer, so it holds stable while stalled
  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      send_msg <= next_msg;
    end
  end

endmodule

/* hdl/fft_top.sv */
`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_top (
  input  logic                     clk,
  input  logic                     rst_n,

  input  fft_pkg::fft_real_frame_t recv_msg,
  input  logic                     recv_val,
  output logic                     recv_rdy,

  output fft_pkg::fft_cplx_frame_t send_msg,
  output logic                     send_val,
  input  logic                     send_rdy
);

  import fft_pkg::*;

  // index with its FFT_N_STAGES low bits in reverse order
  function automatic int rev_idx(input int idx);
    int r;
    r = 0;
    for (int k = 0; k < `FFT_N_STAGES; k++) begin
      r = r | (((idx >> k) & 1) << (`FFT_N_STAGES - 1 - k));
    end
    return r;
  endfunction

  // entry s feeds stage s, the last entry is the output of the chain
  fft_cplx_frame_t cplx_msg  [`FFT_N_STAGES+1];
  logic            stage_val [`FFT_N_STAGES+1];
  logic            stage_rdy [`FFT_N_STAGES+1];

  // real samples in bit-reversed order with a zero imaginary part
  for (genvar i = 0; i < `FFT_N_SAMPLES; i++) begin : g_rev
    assign cplx_msg[0][i].re = recv_msg[rev_idx(i)];
    assign cplx_msg[0][i].im = '0;
  end

  assign stage_val[0] = recv_val;
  assign recv_rdy     = stage_rdy[0];

  for (genvar s = 0; s < `FFT_N_STAGES; s++) begin : g_stage
    fft_stage #(
      .STAGE(s)
    ) u_stage (
      .clk     (clk),
      .rst_n   (rst_n),
      .recv_msg(cplx_msg[s]),
      .recv_val(stage_val[s]),
      .recv_rdy(stage_rdy[s]),
      .send_msg(cplx_msg[s+1]),
      .send_val(stage_val[s+1]),
      .send_rdy(stage_rdy[s+1])
    );
  end

  assign send_msg                 = cplx_msg[`FFT_N_STAGES];
  assign send_val                 = stage_val[`FFT_N_STAGES];
  assign stage_rdy[`FFT_N_STAGES] = send_rdy;  // back-pressure enters the last stage here

endmodule

/* include/fft_defs.svh */
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// width of one signed fixed-point word
`define FFT_BIT_WIDTH 32

// fraction bits of the Q16.16 format
`define FFT_DECIMAL_PT 16

// points per frame, must be a power of two
`define FFT_N_SAMPLES 8

// log2 of the point count, one butterfly stage per bit
`define FFT_N_STAGES 3

`endif

/* project.f */
+incdir+include
hdl/fft_pkg.sv
hdl/fft_butterfly.sv
hdl/fft_stage.sv
hdl/fft_top.sv
sim/tb_fft.sv

/* sim/fft_patterns.hex */
// columns: x[0..7] input samples, then X[0].re X[0].im X[1].re X[1].im ... X[7].im
// all words are 32-bit Q16.16 in hex
00010000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000000
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000 00080000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 0000B505 00000000 FFFF4AFB FFFF0000 FFFF4AFB 00000000 0000B505 00000000 00000000 00040001 FFFFFFFF 00000000 00000000 FFFFFFFF FFFFFFFF 00000000 00000000 FFFFFFFF 00000001 00000000 00000000 00040001 00000001
00030000 FFFF0000 00020000 00050000 FFFC0000 00000000 00010000 FFFE0000 00040000 00000000 000157D8 FFFAC1E2 FFFC0000 00040000 000CA828 FFFCC1E2 00000000 00000000 000CA828 00033E1E FFFC0000 FFFC0000 000157D8 00053E1E
FFFD0000 00010000 FFFE0000 FFFB0000 00040000 00000000 FFFF0000 00020000 FFFC0000 00000000 FFFEA828 00053E1E 00040000 FFFC0000 FFF357D8 00033E1E 00000000 00000000 FFF357D8 FFFCC1E2 00040000 00040000 FFFEA828 FFFAC1E2
00000000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 00010000 00000000 0000B505 FFFF4AFB 00000000 FFFF0000 FFFF4AFB FFFF4AFB FFFF0000 00000000 FFFF4AFB 0000B505 00000000 00010000 0000B505 0000B505

/* sim/tb_fft.sv */
`timescale 1ns/1ps
`include "fft_defs.svh"

module tb_fft;

  import fft_pkg::*;

  localparam int N_PAT     = 6;
  localparam int WORDS     = 24;  // 8 inputs plus 16 expected words per pattern
  localparam int N_RANDOM  = 40;
  localparam int WAIT_MAX  = 200;

  logic            clk;
  logic            rst_n;
  fft_real_frame_t recv_msg;
  logic            recv_val;
  logic            recv_rdy;
  fft_cplx_frame_t send_msg;
  logic            send_val;
  logic            send_rdy;

  logic [31:0] pat_mem [0:N_PAT*WORDS-1];

  int in_q[$];         // pattern index of every accepted frame in order of arrival
  int acc_cycle_q[$];
  int out_cycle_q[$];

  int cycle;
  int cur_pat;
  int in_cnt;
  int out_cnt;
  int err_cnt;
  int chk_cnt;

  logic            hold_valid;
  fft_cplx_frame_t hold_msg;
  logic [16:0]     lfsr;

  fft_top uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .recv_msg(recv_msg),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .send_msg(send_msg),
    .send_val(send_val),
    .send_rdy(send_rdy)
  );

  always #20 clk = ~clk;

  // Fibonacci form of x^17 + x^14 + 1 stepped once per bit
  function automatic logic take_bit();
    logic nb;
    nb   = lfsr[16] ^ lfsr[13];
    lfsr = {lfsr[15:0], nb};
    return nb;
  endfunction

  function automatic fft_real_frame_t frame_in(input int idx);
    fft_real_frame_t f;
    for (int n = 0; n < `FFT_N_SAMPLES; n++) begin
      f[n] = pat_mem[idx*WORDS + n];
    end
    return f;
  endfunction

  task automatic check_frame(input int idx);
    logic [31:0] exp_re;
    logic [31:0] exp_im;
    for (int k = 0; k < `FFT_N_SAMPLES; k++) begin
      exp_re = pat_mem[idx*WORDS + 8 + 2*k];
      exp_im = pat_mem[idx*WORDS + 9 + 2*k];
      chk_cnt += 2;
      assert (send_msg[k].re === exp_re) else begin
        err_cnt++;
        $display("[FAIL] %0t send_msg[%0d].re expected %h got %h (pattern %0d)",
                 $time, k, exp_re, send_msg[k].re, idx);
      end
      assert (send_msg[k].im === exp_im) else begin
        err_cnt++;
        $display("[FAIL] %0t send_msg[%0d].im expected %h got %h (pattern %0d)",
                 $time, k, exp_im, send_msg[k].im, idx);
      end
    end
  endtask

  // watches both handshakes on the rising edge before the DUT registers move
  always @(posedge clk) begin
    int idx;
    if (rst_n) begin
      if (recv_val && recv_rdy) begin
        in_q.push_back(cur_pat);
        acc_cycle_q.push_back(cycle);
        in_cnt++;
      end
      if (hold_valid) begin
        chk_cnt++;
        assert (send_msg === hold_msg) else begin
          err_cnt++;
          $display("[FAIL] %0t send_msg changed under stall expected %h got %h",
                   $time, hold_msg, send_msg);
        end
      end
      if (send_val && send_rdy) begin
        out_cnt++;
        out_cycle_q.push_back(cycle);
        if (in_q.size() == 0) begin
          err_cnt++;
          $display("output frame at %0t has no accepted input frame", $time);
        end else begin
          idx = in_q.pop_front();
          check_frame(idx);
        end
      end
      hold_valid = send_val && !send_rdy;
      hold_msg   = send_msg;
    end
    cycle++;
  end

  task automatic report_timeout(input string what);
    err_cnt++;
    $display("timeout: %s did not happen in time", what);
  endtask

  task automatic clear_history();
    acc_cycle_q.delete();
    out_cycle_q.delete();
  endtask

  task automatic send_single(input int idx);
    int guard;
    bit done;
    guard = 0;
    done  = 0;
    @(negedge clk);
    cur_pat  = idx;
    recv_msg = frame_in(idx);
    recv_val = 1'b1;
    while (!done && guard < WAIT_MAX) begin
      @(posedge clk);
      done = recv_rdy;
      guard++;
    end
    if (!done) begin
      report_timeout("acceptance of a single input frame");
    end
    @(negedge clk);
    recv_val = 1'b0;
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    while (out_cnt != in_cnt && guard < WAIT_MAX) begin
      @(negedge clk);
      guard++;
    end
    if (out_cnt != in_cnt) begin
      report_timeout("output of every accepted frame");
    end
  endtask

  task automatic stream_frames(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      cur_pat  = i % N_PAT;
      recv_msg = frame_in(cur_pat);
      recv_val = 1'b1;
      @(posedge clk);
      chk_cnt++;
      assert (recv_rdy === 1'b1) else begin
        err_cnt++;
        $display("[FAIL] %0t recv_rdy expected 1 got %b while streaming", $time, recv_rdy);
      end
    end
    @(negedge clk);
    recv_val = 1'b0;
  endtask

  // random offers under random back-pressure where each offer is held until it is taken
  task automatic random_traffic(input int n);
    int sent;
    int guard;
    bit taken;
    sent  = 0;
    guard = 0;
    taken = 0;
    while (sent < n && guard < WAIT_MAX * n) begin
      @(negedge clk);
      guard++;
      if (taken) recv_val = 1'b0;
      send_rdy = take_bit();
      if (!recv_val && take_bit()) begin
        cur_pat  = sent % N_PAT;
        recv_msg = frame_in(cur_pat);
        recv_val = 1'b1;
      end
      @(posedge clk);
      taken = recv_val && recv_rdy;
      if (taken) sent++;
    end
    if (sent < n) begin
      report_timeout("acceptance of all random frames");
    end
    @(negedge clk);
    recv_val = 1'b0;
    send_rdy = 1'b1;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    recv_msg   = '0;
    recv_val   = 1'b0;
    send_rdy   = 1'b0;
    cycle      = 0;
    cur_pat    = 0;
    in_cnt     = 0;
    out_cnt    = 0;
    err_cnt    = 0;
    chk_cnt    = 0;
    hold_valid = 1'b0;
    hold_msg   = '0;
    lfsr       = 17'd75865;

    $readmemh("sim/fft_patterns.hex", pat_mem);
    assert (!$isunknown(pat_mem[N_PAT*WORDS-1])) else begin
      err_cnt++;
      $display("pattern file is missing or shorter than expected");
    end

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    #1;
    // send_rdy is still low here so recv_rdy can only be high through empty stages
    chk_cnt += 2;
    assert (send_val === 1'b0) else begin
      err_cnt++;
      $display("[FAIL] %0t send_val expected 0 got %b after reset", $time, send_val);
    end
    assert (recv_rdy === 1'b1) else begin
      err_cnt++;
      $display("[FAIL] %0t recv_rdy expected 1 got %b after reset", $time, recv_rdy);
    end
    @(negedge clk);
    send_rdy = 1'b1;

    // each pattern alone also gives the latency
    for (int p = 0; p < N_PAT; p++) begin
      clear_history();
      send_single(p);
      wait_drain();
      chk_cnt++;
      assert (out_cycle_q[0] - acc_cycle_q[0] == 3) else begin
        err_cnt++;
        $display("[FAIL] %0t latency expected 3 got %0d", $time,
                 out_cycle_q[0] - acc_cycle_q[0]);
      end
    end

    clear_history();
    stream_frames(2 * N_PAT);
    wait_drain();
    for (int i = 1; i < out_cycle_q.size(); i++) begin
      chk_cnt++;
      assert (out_cycle_q[i] == out_cycle_q[i-1] + 1) else begin
        err_cnt++;
        $display("[FAIL] %0t output gap expected 1 got %0d", $time,
                 out_cycle_q[i] - out_cycle_q[i-1]);
      end
    end

    random_traffic(N_RANDOM);
    wait_drain();
    chk_cnt++;
    assert (out_cnt == in_cnt && in_q.size() == 0) else begin
      err_cnt++;
      $display("[FAIL] %0t frames out expected %0d got %0d", $time, in_cnt, out_cnt);
    end

    $display("checks %0d, errors %0d, frames in %0d, frames out %0d",
             chk_cnt, err_cnt, in_cnt, out_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
